//--- Makefile
VERILATOR ?= verilator
TOP       ?= asteroid_game_tb
FILELIST  ?= asteroid_game.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

.PHONY: build

//--- asteroid_game.f
source/astro_pkg.sv
source/dp_ctrl_if.sv
source/life_counter.sv
source/game_datapath.sv
source/game_control.sv
source/asteroid_game.sv
sim/asteroid_game_tb.sv

//--- sim/asteroid_game_tb.sv
`timescale 1ns/1ns

module asteroid_game_tb;

    localparam logic [3:0] SPAWN_X     = 4'd15;
    localparam logic [3:0] SPAWN_Y     = 4'd6;
    localparam logic [3:0] SHIP_X      = 4'd1;
    localparam logic [3:0] START_LIVES = 4'd3;
    localparam int         WAIT_LIMIT  = 40;

    logic        clock;
    logic        arst_n;
    logic        start;
    logic        tick;
    logic [5:0]  move;
    logic [3:0]  asteroid_x;
    logic [3:0]  asteroid_y;
    logic [3:0]  lives;
    logic        game_over;
    logic        hit;
    logic        collision;
    logic [5:0]  move_db;

    // reference model state
    logic [3:0]  exp_x;
    logic [3:0]  exp_y;
    logic [3:0]  exp_lives;
    logic [5:0]  exp_move;
    logic        exp_over;
    logic [31:0] rng;
    int          hits_seen;
    int          crashes_seen;

    asteroid_game DUT (
        .clock      (clock),
        .arst_n     (arst_n),
        .start      (start),
        .tick       (tick),
        .move       (move),
        .asteroid_x (asteroid_x),
        .asteroid_y (asteroid_y),
        .lives      (lives),
        .game_over  (game_over),
        .hit        (hit),
        .collision  (collision),
        .move_db    (move_db)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] r;
        r = s ^ (s << 13);
        r = r ^ (r >> 17);
        r = r ^ (r << 5);
        return r;
    endfunction

    task automatic check_position();
        check("asteroid_x", 32'(asteroid_x), 32'(exp_x));
        check("asteroid_y", 32'(asteroid_y), 32'(exp_y));
        check("lives", 32'(lives), 32'(exp_lives));
    endtask

    task automatic start_game();
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        exp_x     = SPAWN_X;
        exp_y     = SPAWN_Y;
        exp_lives = START_LIVES;
        exp_over  = 1'b0;
        check_position();
        check("game_over", 32'(game_over), 32'd0);
    endtask

    task automatic apply_tick(input logic [5:0] mv);
        logic [3:0] step;
        logic       exp_hit;
        logic       exp_crash;
        int         k;
        exp_hit   = 1'b0;
        exp_crash = 1'b0;
        if (!exp_over) begin
            exp_move = mv;
            step     = (exp_x >= 4'd8) ? 4'd2 : 4'd1;
            exp_x    = exp_x - step;
            if (exp_y != 4'd0) begin
                exp_y = exp_y - 4'd1;
            end
            exp_hit   = mv[0] && (exp_y == 4'd0);
            exp_crash = !exp_hit && (exp_x == SHIP_X) && (exp_y == 4'd0);
            if (exp_crash) begin
                exp_lives = exp_lives - 4'd1;
            end
            if (exp_hit || exp_crash) begin
                exp_x = SPAWN_X;
                exp_y = SPAWN_Y;
            end
            if (exp_lives == 4'd0) begin
                exp_over = 1'b1;
            end
        end
        @(negedge clock);
        tick = 1'b1;
        move = mv;
        @(negedge clock);
        tick = 1'b0;
        // sample k sits after edge n+k and the pulse belongs to k == 3
        for (k = 0; k < 6; k++) begin
            check("hit", 32'(hit), 32'(exp_hit && (k == 3)));
            check("collision", 32'(collision), 32'(exp_crash && (k == 3)));
            if (hit) begin
                hits_seen++;
            end
            if (collision) begin
                crashes_seen++;
            end
            if (k < 5) begin
                @(negedge clock);
            end
        end
        check_position();
        check("game_over", 32'(game_over), 32'(exp_over));
        check("move_db", 32'(move_db), 32'(exp_move));
    endtask

    task automatic wait_game_over();
        int n;
        n = 0;
        while (!game_over && n < WAIT_LIMIT) begin
            @(negedge clock);
            n++;
        end
        if (!game_over) begin
            abort_run("timeout: game_over never went high after the last life was lost");
        end
    endtask

    task automatic reset_and_start();
        check("game_over", 32'(game_over), 32'd0);
        check("hit", 32'(hit), 32'd0);
        check("collision", 32'(collision), 32'd0);
        check_position();
        check("move_db", 32'(move_db), 32'd0);
        start_game();
    endtask

    task automatic step_asteroid();
        repeat (5) begin
            rng = xorshift(rng);
            apply_tick(rng[5:0] & 6'h3e);
        end
    endtask

    task automatic shoot_asteroid();
        hits_seen = 0;
        // shot while the asteroid is still high up
        rng = xorshift(rng);
        apply_tick(rng[5:0] | 6'h01);
        repeat (4) begin
            rng = xorshift(rng);
            apply_tick(rng[5:0] & 6'h3e);
        end
        // this step lands on row 0
        rng = xorshift(rng);
        apply_tick(rng[5:0] | 6'h01);
        check("hits_seen", 32'(hits_seen), 32'd1);
    endtask

    task automatic collide_once();
        crashes_seen = 0;
        repeat (10) begin
            rng = xorshift(rng);
            apply_tick(rng[5:0] & 6'h3e);
        end
        check("crashes_seen", 32'(crashes_seen), 32'd1);
        check("lives", 32'(lives), 32'd2);
    endtask

    task automatic lose_all_lives();
        repeat (20) begin
            rng = xorshift(rng);
            apply_tick(rng[5:0] & 6'h3e);
        end
        wait_game_over();
        check("lives", 32'(lives), 32'd0);
        // ignored while over
        repeat (2) begin
            rng = xorshift(rng);
            apply_tick(rng[5:0]);
        end
        start_game();
    endtask

    task automatic track_move_debug();
        repeat (4) begin
            rng = xorshift(rng);
            apply_tick(rng[5:0]);
        end
        check("move_db", 32'(move_db), 32'(exp_move));
    endtask

    initial begin
        #20000;
        abort_run("timeout: the test sequence did not finish");
    end

    initial begin
        arst_n       = 1'b0;
        start        = 1'b0;
        tick         = 1'b0;
        move         = '0;
        rng          = 32'h045c_fc10;
        hits_seen    = 0;
        crashes_seen = 0;
        exp_x        = '0;
        exp_y        = '0;
        exp_lives    = '0;
        exp_move     = '0;
        exp_over     = 1'b0;
        repeat (3) @(negedge clock);
        arst_n = 1'b1;
        reset_and_start();
        shoot_asteroid();
        step_asteroid();
        collide_once();
        lose_all_lives();
        track_move_debug();
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- source/asteroid_game.sv
`timescale 1ns/1ns

module asteroid_game (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          start,
    input  logic                          tick,
    input  logic [astro_pkg::MOVE_W-1:0]  move,
    output logic [astro_pkg::COORD_W-1:0] asteroid_x,
    output logic [astro_pkg::COORD_W-1:0] asteroid_y,
    output logic [astro_pkg::LIVES_W-1:0] lives,
    output logic                          game_over,
    output logic                          hit,
    output logic                          collision,
    output logic [astro_pkg::MOVE_W-1:0]  move_db
);

    dp_ctrl_if bus ();

    game_control u_control (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .tick      (tick),
        .bus       (bus),
        .hit       (hit),
        .collision (collision),
        .game_over (game_over)
    );

    // coordinates, move latch and lives
    game_datapath u_datapath (
        .clock      (clock),
        .arst_n     (arst_n),
        .move       (move),
        .bus        (bus),
        .asteroid_x (asteroid_x),
        .asteroid_y (asteroid_y),
        .lives      (lives),
        .move_db    (move_db)
    );

endmodule

//--- source/astro_pkg.sv
package astro_pkg;

    // grid and datapath widths
    localparam int COORD_W = 4;
    localparam int MOVE_W  = 6;
    localparam int LIVES_W = 4;

    localparam logic [LIVES_W-1:0] LIVES_INIT = 4'd3;

    // ship never moves
    localparam logic [COORD_W-1:0] SHIP_X = 4'd1;
    localparam logic [COORD_W-1:0] SHIP_Y = 4'd0;

    // asteroid enters at the right edge
    localparam logic [COORD_W-1:0] SPAWN_X = 4'd15;
    localparam logic [COORD_W-1:0] SPAWN_Y = 4'd6;

    // x moves faster on the far half of the grid
    localparam logic [COORD_W-1:0] STEP_NEAR = 4'd1;
    localparam logic [COORD_W-1:0] STEP_FAR  = 4'd2;
    localparam logic [COORD_W-1:0] FAR_LIMIT = 4'd8;

    // move vector is {up, down, right, left, special, shot}
    localparam int MOVE_SHOT = 0;

    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        PLAY    = 3'd1,
        STEP_X  = 3'd2,
        STEP_Y  = 3'd3,
        RESOLVE = 3'd4,
        OVER    = 3'd5
    } game_state_t;

endpackage

//--- source/dp_ctrl_if.sv
`timescale 1ns/1ns

interface dp_ctrl_if;

    // control strobes
    logic spawn;
    logic latch_move;
    logic en_x;
    logic en_y;
    logic sel_x;
    logic sel_far;
    logic load_lives;
    logic dec_lives;

    // datapath status
    logic x_far;
    logic y_zero;
    logic row_match;
    logic ship_hit_pos;
    logic shot;
    logic lives_zero;

    modport ctrl (
        output spawn, latch_move, en_x, en_y, sel_x, sel_far, load_lives, dec_lives,
        input  x_far, y_zero, row_match, ship_hit_pos, shot, lives_zero
    );

    modport dp (
        input  spawn, latch_move, en_x, en_y, sel_x, sel_far, load_lives, dec_lives,
        output x_far, y_zero, row_match, ship_hit_pos, shot, lives_zero
    );

endinterface

//--- source/game_control.sv
`timescale 1ns/1ns

module game_control (
    input  logic    clock,
    input  logic    arst_n,
    input  logic    start,
    input  logic    tick,
    dp_ctrl_if.ctrl bus,
    output logic    hit,
    output logic    collision,
    output logic    game_over
);
    import astro_pkg::*;

    game_state_t state;
    game_state_t state_next;
    logic        settle;
    logic        hit_now;
    logic        crash_now;

    // resolve runs two cycles to judge then apply
    assign hit_now   = (state == RESOLVE) && !settle && bus.shot && bus.row_match;
    assign crash_now = (state == RESOLVE) && !settle && !hit_now && bus.ship_hit_pos;

    always_comb begin
        state_next     = state;
        bus.spawn      = 1'b0;
        bus.latch_move = 1'b0;
        bus.en_x       = 1'b0;
        bus.en_y       = 1'b0;
        bus.sel_x      = 1'b0;
        bus.sel_far    = 1'b0;
        bus.load_lives = 1'b0;
        bus.dec_lives  = 1'b0;
        case (state)
            IDLE, OVER: begin
                if (start) begin
                    bus.load_lives = 1'b1;
                    bus.spawn      = 1'b1;
                    state_next     = PLAY;
                end
            end
            PLAY: begin
                if (bus.lives_zero) begin
                    state_next = OVER;
                end else if (tick) begin
                    bus.latch_move = 1'b1;
                    state_next     = STEP_X;
                end
            end
            STEP_X: begin
                bus.en_x    = 1'b1;
                bus.sel_x   = 1'b1;
                bus.sel_far = bus.x_far;
                state_next  = STEP_Y;
            end
            STEP_Y: begin
                // y parks on row 0
                bus.en_y   = !bus.y_zero;
                state_next = RESOLVE;
            end
            RESOLVE: begin
                if (settle) begin
                    bus.spawn     = hit || collision;
                    bus.dec_lives = collision;
                    state_next    = PLAY;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= IDLE;
            settle    <= 1'b0;
            hit       <= 1'b0;
            collision <= 1'b0;
            game_over <= 1'b0;
        end else begin
            state     <= state_next;
            settle    <= (state == RESOLVE) && !settle;
            hit       <= hit_now;
            collision <= crash_now;
            game_over <= (state_next == OVER);
        end
    end

    over_means_no_lives: assert property (
        @(posedge clock) disable iff (!arst_n)
        game_over |-> bus.lives_zero
    ) else $error("game_control: game_over with lives remaining");

endmodule

//--- source/game_datapath.sv
`timescale 1ns/1ns

module game_datapath (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic [astro_pkg::MOVE_W-1:0]  move,
    dp_ctrl_if.dp                         bus,
    output logic [astro_pkg::COORD_W-1:0] asteroid_x,
    output logic [astro_pkg::COORD_W-1:0] asteroid_y,
    output logic [astro_pkg::LIVES_W-1:0] lives,
    output logic [astro_pkg::MOVE_W-1:0]  move_db
);
    import astro_pkg::*;

    logic [MOVE_W-1:0]  move_q;
    logic [COORD_W-1:0] coord_x;
    logic [COORD_W-1:0] coord_y;
    logic [COORD_W-1:0] operand;
    logic [COORD_W-1:0] step;
    logic [COORD_W-1:0] diff;

    // player move, only sampled on a tick
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            move_q <= '0;
        end else if (bus.latch_move) begin
            move_q <= move;
        end
    end

    // one subtractor shared by both coordinates
    assign operand = bus.sel_x ? coord_x : coord_y;
    assign step    = bus.sel_far ? STEP_FAR : STEP_NEAR;

    // wraps modulo 16
    assign diff = operand - step;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            coord_x <= '0;
        end else if (bus.spawn) begin
            coord_x <= SPAWN_X;
        end else if (bus.en_x) begin
            coord_x <= diff;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            coord_y <= '0;
        end else if (bus.spawn) begin
            coord_y <= SPAWN_Y;
        end else if (bus.en_y) begin
            coord_y <= diff;
        end
    end

    life_counter u_lives (
        .clock  (clock),
        .arst_n (arst_n),
        .load   (bus.load_lives),
        .dec    (bus.dec_lives),
        .count  (lives),
        .zero   (bus.lives_zero)
    );

    // status back to control
    assign bus.x_far        = (coord_x >= FAR_LIMIT);
    assign bus.y_zero       = (coord_y == '0);
    assign bus.row_match    = (coord_y == SHIP_Y);
    assign bus.ship_hit_pos = (coord_x == SHIP_X) && (coord_y == SHIP_Y);
    assign bus.shot         = move_q[MOVE_SHOT];

    assign asteroid_x = coord_x;
    assign asteroid_y = coord_y;
    assign move_db    = move_q;

    // the subtractor serves one coordinate per cycle
    one_coord_per_cycle: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(bus.en_x && bus.en_y)
    ) else $error("game_datapath: en_x and en_y raised together");

endmodule

//--- source/life_counter.sv
`timescale 1ns/1ns

module life_counter (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          load,
    input  logic                          dec,
    output logic [astro_pkg::LIVES_W-1:0] count,
    output logic                          zero
);
    import astro_pkg::*;

    assign zero = (count == '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (load) begin
            count <= LIVES_INIT;
        end else if (dec && !zero) begin
            // holds at zero, no wrap to 15
            count <= count - 1'b1;
        end
    end

    // control must stop asking for decrements once lives are gone
    dec_when_empty: assert property (
        @(posedge clock) disable iff (!arst_n)
        !(dec && zero)
    ) else $error("life_counter: dec requested with zero lives");

endmodule
